// File: all.f
+incdir+source
source/merge_pkg.sv
source/merge_net_if.sv
source/block_fifo.sv
source/bitonic_merger.sv
source/merge_control.sv
source/block_drain.sv
source/merge_node.sv
dv/merge_checker.sv
dv/merge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the merge node testbench with Verilator, run it, then scan the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module merge_tb -f all.f -o merge_sim > build.log 2>&1 \
   && ./obj_dir/merge_sim > sim.log 2>&1 \
   || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log \
   && { echo "Simulation reported a failure"; exit 1; } \
   || { echo "Simulation reported no failure"; exit 0; }

// File: dv/merge_tb.sv
`timescale 1ns/1ps
`include "merge_consts.svh"

module merge_tb;
   localparam int BW          = `MRG_BLK*`MRG_REC_W;
   localparam int RUN_TIMEOUT = 4000;   // Cycles allowed per run.

   typedef logic [BW-1:0]         flat_t;
   typedef logic [`MRG_REC_W-1:0] rec_t;

   logic  clk;
   logic  rst_n;
   flat_t a_blk;
   logic  a_empty;
   logic  a_read;
   flat_t b_blk;
   logic  b_empty;
   logic  b_read;
   logic  out_ready;
   logic  out_write;
   flat_t out_blk;
   logic  run_end;

   flat_t a_q[$];
   flat_t b_q[$];
   int    ready_mode;   // 0 always ready, 1 random, 2 held low.
   int    ends;
   int    errors;
   int    runs;
   int    test_no;
   int    fails;
   logic  timed_out;

   merge_node dut_i (
      .i_clk       (clk),
      .i_rst_n     (rst_n),
      .i_a_blk     (a_blk),
      .i_a_empty   (a_empty),
      .o_a_read    (a_read),
      .i_b_blk     (b_blk),
      .i_b_empty   (b_empty),
      .o_b_read    (b_read),
      .i_out_ready (out_ready),
      .o_out_write (out_write),
      .o_out_blk   (out_blk),
      .o_run_end   (run_end)
   );

   merge_checker chk_i (
      .i_clk       (clk),
      .i_rst_n     (rst_n),
      .i_a_blk     (a_blk),
      .i_a_empty   (a_empty),
      .i_a_read    (a_read),
      .i_b_blk     (b_blk),
      .i_b_empty   (b_empty),
      .i_b_read    (b_read),
      .i_out_ready (out_ready),
      .i_out_write (out_write),
      .i_out_blk   (out_blk),
      .i_run_end   (run_end),
      .o_errors    (errors),
      .o_runs      (runs)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // ########################################
   // Upstream FIFOs and downstream ready
   // ########################################

   always @(posedge clk) begin
      if (a_read && !a_empty) void'(a_q.pop_front());
      if (b_read && !b_empty) void'(b_q.pop_front());
      a_empty <= 1'b1;
      b_empty <= 1'b1;
      if (rst_n && a_q.size() > 0 && ($urandom % 4) != 0) begin
         a_blk   <= a_q[0];
         a_empty <= 1'b0;
      end
      if (rst_n && b_q.size() > 0 && ($urandom % 4) != 0) begin
         b_blk   <= b_q[0];
         b_empty <= 1'b0;
      end
      case (ready_mode)
         0:       out_ready <= 1'b1;
         1:       out_ready <= ($urandom % 4) != 0;
         default: out_ready <= 1'b0;
      endcase
      if (rst_n && run_end) ends <= ends + 1;
   end

   // Sorted nonzero keys packed into blocks, then the zero block.
   task automatic load_run(input logic to_b, input int nblk, input int kmax);
      int    keys[$];
      flat_t blk;
      int    i;
      for (i = 0; i < nblk*`MRG_BLK; i++) keys.push_back(1 + int'($urandom % kmax));
      keys.sort();
      blk = '0;
      for (i = 0; i < keys.size(); i++) begin
         blk[(i % `MRG_BLK)*`MRG_REC_W +: `MRG_REC_W] = rec_t'(keys[i]);
         if ((i % `MRG_BLK) == `MRG_BLK - 1) begin
            if (to_b) b_q.push_back(blk);
            else a_q.push_back(blk);
         end
      end
      if (to_b) b_q.push_back('0);
      else a_q.push_back('0);
   endtask

   task automatic wait_runs(input int target, output logic ok);
      int cyc;
      cyc = 0;
      while (ends < target && cyc < RUN_TIMEOUT) begin
         @(posedge clk);
         cyc++;
      end
      ok = (ends >= target);
      if (!ok) $display("Timeout: run %0d did not end within %0d cycles", target, RUN_TIMEOUT);
   endtask

   task automatic run_test(input string name, input int na, input int nb, input int kmax,
                           input logic stall);
      int   err0;
      logic ok;
      if (timed_out) return;
      test_no++;
      err0 = errors;
      @(negedge clk);
      load_run(1'b0, na, kmax);
      load_run(1'b1, nb, kmax);
      if (stall) begin
         ready_mode = 2;
         repeat (100) @(posedge clk);
         @(negedge clk);
         ready_mode = 1;
      end
      wait_runs(test_no, ok);
      @(negedge clk);
      if (!ok) timed_out = 1'b1;
      if (!ok || errors != err0) fails++;
      $display("Test %0d %s (%0d + %0d blocks): %s", test_no, name, na, nb,
               (ok && errors == err0) ? "pass" : "fail");
   endtask

   // ########################################
   // Test sequence
   // ########################################

   initial begin
      int n;
      void'($urandom(69));
      rst_n      = 1'b0;
      a_blk      = '0;
      a_empty    = 1'b1;
      b_blk      = '0;
      b_empty    = 1'b1;
      out_ready  = 1'b0;
      ready_mode = 0;
      ends       = 0;
      test_no    = 0;
      fails      = 0;
      timed_out  = 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      repeat (8) @(posedge clk);   // Idle, both upstreams empty.
      run_test("equal lengths", 3, 3, 1000, 1'b0);
      run_test("empty A run", 0, 4, 1000, 1'b0);
      run_test("empty B run", 5, 0, 1000, 1'b0);
      run_test("both runs empty", 0, 0, 1000, 1'b0);
      run_test("unequal lengths", 1, 9, 1000, 1'b0);
      run_test("duplicate keys", 4, 4, 12, 1'b0);
      run_test("back-pressure", 30, 30, 5000, 1'b1);
      for (n = 0; n < 4; n++) begin
         run_test("random lengths", int'($urandom % 7), int'($urandom % 7), 5000, 1'b0);
      end
      $display("Tests: %0d, failed tests: %0d, failed checks: %0d, runs compared: %0d",
               test_no, fails, errors, runs);
      if (fails == 0 && errors == 0 && !timed_out) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: dv/merge_checker.sv
`timescale 1ns/1ps
`include "merge_consts.svh"

module merge_checker (
   input  logic                           i_clk,
   input  logic                           i_rst_n,
   input  logic [`MRG_BLK*`MRG_REC_W-1:0] i_a_blk,
   input  logic                           i_a_empty,
   input  logic                           i_a_read,
   input  logic [`MRG_BLK*`MRG_REC_W-1:0] i_b_blk,
   input  logic                           i_b_empty,
   input  logic                           i_b_read,
   input  logic                           i_out_ready,
   input  logic                           i_out_write,
   input  logic [`MRG_BLK*`MRG_REC_W-1:0] i_out_blk,
   input  logic                           i_run_end,
   output int                             o_errors,
   output int                             o_runs
);
   localparam int N           = `MRG_BLK;
   localparam int STALL_LIMIT = 50;   // Low ready cycles after which reads must be over.

   typedef logic [N*`MRG_REC_W-1:0] flat_t;
   typedef logic [`MRG_REC_W-1:0]   rec_t;

   int    a_keys[$];
   int    b_keys[$];
   flat_t exp_q[$];
   flat_t got_q[$];
   logic  a_done;
   logic  b_done;
   logic  any_input;
   int    last_key;
   int    low_cycles;
   int    k;

   function automatic int key_at(input flat_t blk, input int idx);
      return int'(blk[idx*`MRG_REC_W +: `MRG_KEY_W]);
   endfunction

   task automatic fail_value(input string msg);
      o_errors++;
      $display("[FAIL] %0t: %s", $time, msg);
   endtask

   task automatic fail_rule(input string msg);
      o_errors++;
      $display("Check failed at %0t: %s", $time, msg);
   endtask

   // ########################################
   // Reference merge
   // ########################################

   task automatic build_expected();
      int    keys[$];
      flat_t blk;
      int    i;
      keys = a_keys;
      foreach (b_keys[j]) keys.push_back(b_keys[j]);
      keys.sort();
      blk = '0;
      for (i = 0; i < keys.size(); i++) begin
         blk[(i % N)*`MRG_REC_W +: `MRG_REC_W] = rec_t'(keys[i]);
         if ((i % N) == N - 1) begin
            exp_q.push_back(blk);
         end
      end
      exp_q.push_back('0);   // Terminator.
      a_keys.delete();
      b_keys.delete();
      a_done = 1'b0;
      b_done = 1'b0;
   endtask

   task automatic compare_run();
      flat_t exp_blk;
      int    i;
      for (i = 0; i < got_q.size() && exp_q.size() > 0; i++) begin
         exp_blk = exp_q.pop_front();
         assert (got_q[i] == exp_blk)
            else fail_value($sformatf("run %0d block %0d is %h, expected %h",
                                      o_runs, i, got_q[i], exp_blk));
      end
      assert (i == got_q.size()) else fail_rule("the run has more blocks than expected");
      assert (exp_q.size() == 0) else fail_rule("the run ended with blocks missing");
      exp_q.delete();
      got_q.delete();
      last_key = 0;
      o_runs++;
   endtask

   // ########################################
   // Monitor
   // ########################################

   always @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_errors   = 0;
         o_runs     = 0;
         last_key   = 0;
         low_cycles = 0;
         a_done     = 1'b0;
         b_done     = 1'b0;
         any_input  = 1'b0;
         a_keys.delete();
         b_keys.delete();
         exp_q.delete();
         got_q.delete();
      end else begin
         if (!i_a_empty || !i_b_empty) any_input = 1'b1;
         if (!any_input) begin
            assert (!i_a_read && !i_b_read && !i_out_write && !i_run_end)
               else fail_rule("an output was active before any input");
         end
         assert (!(i_a_read && i_a_empty)) else fail_rule("A was read while empty");
         assert (!(i_b_read && i_b_empty)) else fail_rule("B was read while empty");

         low_cycles = i_out_ready ? 0 : low_cycles + 1;
         if (low_cycles > STALL_LIMIT) begin
            assert (!i_a_read && !i_b_read) else fail_rule("reads go on under back-pressure");
         end

         // Input streams feed the reference.
         if (i_a_read && !i_a_empty) begin
            if (i_a_blk == '0) a_done = 1'b1;
            else for (k = 0; k < N; k++) a_keys.push_back(key_at(i_a_blk, k));
         end
         if (i_b_read && !i_b_empty) begin
            if (i_b_blk == '0) b_done = 1'b1;
            else for (k = 0; k < N; k++) b_keys.push_back(key_at(i_b_blk, k));
         end
         if (a_done && b_done) build_expected();

         assert (!i_run_end || i_out_write) else fail_rule("run end was raised without a write");
         if (i_out_write) begin
            if (i_out_blk != '0) begin
               for (k = 1; k < N; k++) begin
                  assert (key_at(i_out_blk, k) >= key_at(i_out_blk, k - 1))
                     else fail_value($sformatf("block %h is not ascending", i_out_blk));
               end
               assert (key_at(i_out_blk, 0) >= last_key)
                  else fail_value($sformatf("block %h starts below key %0d",
                                            i_out_blk, last_key));
               last_key = key_at(i_out_blk, N - 1);
            end
            assert (i_run_end == (i_out_blk == '0))
               else fail_value($sformatf("run end is %b on block %h", i_run_end, i_out_blk));
            got_q.push_back(i_out_blk);
            if (i_out_blk == '0) compare_run();
         end
      end
   end

endmodule

// File: source/merge_node.sv
`timescale 1ns/1ps
`include "merge_consts.svh"

module merge_node (
   input  logic                           i_clk,
   input  logic                           i_rst_n,
   input  logic [`MRG_BLK*`MRG_REC_W-1:0] i_a_blk,
   input  logic                           i_a_empty,
   output logic                           o_a_read,
   input  logic [`MRG_BLK*`MRG_REC_W-1:0] i_b_blk,
   input  logic                           i_b_empty,
   output logic                           o_b_read,
   input  logic                           i_out_ready,
   output logic                           o_out_write,
   output logic [`MRG_BLK*`MRG_REC_W-1:0] o_out_blk,
   output logic                           o_run_end
);
   import merge_pkg::*;

   logic wr;
   blk_t wr_blk;
   logic out_full;
   logic out_empty;
   logic rd;
   blk_t head_blk;

   merge_net_if net_if ();

   merge_control ctrl_i (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_a_blk    (i_a_blk),
      .i_a_empty  (i_a_empty),
      .o_a_read   (o_a_read),
      .i_b_blk    (i_b_blk),
      .i_b_empty  (i_b_empty),
      .o_b_read   (o_b_read),
      .i_out_full (out_full),
      .o_wr       (wr),
      .o_wr_blk   (wr_blk),
      .net        (net_if.ctrl)
   );

   bitonic_merger merger_i (
      .net (net_if.net)
   );

   block_fifo #(
      .DEPTH (`MRG_OUT_DEPTH)
   ) out_fifo_i (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_wr     (wr),
      .i_wr_blk (wr_blk),
      .i_rd     (rd),
      .o_rd_blk (head_blk),
      .o_empty  (out_empty),
      .o_full   (out_full)
   );

   block_drain drain_i (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_out_ready (i_out_ready),
      .i_empty     (out_empty),
      .i_head_blk  (head_blk),
      .o_rd        (rd),
      .o_out_write (o_out_write),
      .o_out_blk   (o_out_blk),
      .o_run_end   (o_run_end)
   );

endmodule

// File: source/block_drain.sv
`timescale 1ns/1ps

module block_drain (
   input  logic            i_clk,
   input  logic            i_rst_n,
   input  logic            i_out_ready,
   input  logic            i_empty,
   input  merge_pkg::blk_t i_head_blk,
   output logic            o_rd,
   output logic            o_out_write,
   output merge_pkg::blk_t o_out_blk,
   output logic            o_run_end
);
   import merge_pkg::*;

   logic ready_q;
   logic head_zero;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= i_out_ready;   // Downstream room, one cycle late.
      end
   end

   assign head_zero = (i_head_blk == '0);

   // Pop and write downstream in the same cycle.
   assign o_rd        = ready_q && !i_empty;
   assign o_out_write = o_rd;
   assign o_out_blk   = i_head_blk;
   assign o_run_end   = o_rd && head_zero;   // Terminator leaving.

endmodule

// File: source/merge_control.sv
`timescale 1ns/1ps

module merge_control (
   input  logic            i_clk,
   input  logic            i_rst_n,
   input  merge_pkg::blk_t i_a_blk,
   input  logic            i_a_empty,
   output logic            o_a_read,
   input  merge_pkg::blk_t i_b_blk,
   input  logic            i_b_empty,
   output logic            o_b_read,
   input  logic            i_out_full,
   output logic            o_wr,
   output merge_pkg::blk_t o_wr_blk,
   merge_net_if.ctrl       net
);
   import merge_pkg::*;

   ctrl_state_e state;
   blk_t        top_blk;
   blk_t        pend_blk;   // Block waiting to enter the output FIFO.
   logic        pend_vld;
   logic        a_end;
   logic        b_end;
   logic        use_a;
   logic        use_b;
   blk_t        head_blk;
   logic        head_zero;
   logic        pop;

   // ########################################
   // Head selection
   // ########################################

   always_comb begin
      use_a = 1'b0;
      use_b = 1'b0;
      if (a_end && !b_end) begin
         use_b = !i_b_empty;
      end else if (b_end && !a_end) begin
         use_a = !i_a_empty;
      end else if (!a_end && !b_end && !i_a_empty && !i_b_empty) begin
         // Ties go to A.
         if (rec_key(i_a_blk[0]) <= rec_key(i_b_blk[0])) begin
            use_a = 1'b1;
         end else begin
            use_b = 1'b1;
         end
      end
   end

   assign head_blk  = use_a ? i_a_blk : i_b_blk;
   assign head_zero = (head_blk == '0);  // Run terminator.

   always_comb begin
      case (state)
         FILL:    pop = use_a || use_b;
         MERGE:   pop = (use_a || use_b) && !i_out_full;
         default: pop = 1'b0;
      endcase
   end

   assign o_a_read    = pop && use_a;
   assign o_b_read    = pop && use_b;
   assign net.blk_new = head_blk;
   assign net.blk_top = top_blk;
   assign o_wr        = pend_vld && !i_out_full;
   assign o_wr_blk    = pend_blk;

   // ########################################
   // State and stream flags
   // ########################################

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state    <= FILL;
         pend_vld <= 1'b0;
         a_end    <= 1'b0;
         b_end    <= 1'b0;
      end else begin
         if (!i_out_full) begin
            pend_vld <= 1'b0;   // Pending block commits.
         end
         if (o_a_read && head_zero) begin
            a_end <= 1'b1;
         end
         if (o_b_read && head_zero) begin
            b_end <= 1'b1;
         end
         case (state)
            FILL: begin
               if (a_end && b_end) begin
                  state <= FLUSH_END;   // Both runs were empty.
               end else if (pop && !head_zero) begin
                  state <= MERGE;
               end
            end
            MERGE: begin
               if (a_end && b_end) begin
                  state <= FLUSH_TOP;
               end else if (pop && !head_zero) begin
                  pend_vld <= 1'b1;
               end
            end
            FLUSH_TOP: begin
               if (!i_out_full) begin
                  pend_vld <= 1'b1;
                  state    <= FLUSH_END;
               end
            end
            FLUSH_END: begin
               if (!i_out_full) begin
                  pend_vld <= 1'b1;
                  a_end    <= 1'b0;
                  b_end    <= 1'b0;
                  state    <= FILL;
               end
            end
            default: state <= FILL;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == FILL && pop && !head_zero) begin
         top_blk <= head_blk;
      end
      if (state == MERGE && pop && !head_zero) begin
         top_blk  <= net.blk_hi;
         pend_blk <= net.blk_lo;
      end
      if (state == FLUSH_TOP && !i_out_full) begin
         pend_blk <= top_blk;
      end
      if (state == FLUSH_END && !i_out_full) begin
         pend_blk <= '0;
      end
   end

endmodule

// File: source/bitonic_merger.sv
`timescale 1ns/1ps
`include "merge_consts.svh"

module bitonic_merger (
   merge_net_if.net net
);
   import merge_pkg::*;

   localparam int N   = `MRG_BLK;
   localparam int N2  = 2 * N;
   localparam int LVL = $clog2(N2);

   // Stage 0 is the bitonic input, stage LVL the sorted union.
   rec_t stg [LVL+1][N2];

   // ########################################
   // Bitonic input
   // ########################################

   for (genvar i = 0; i < N; i++) begin : g_in
      assign stg[0][i]     = net.blk_new[i];
      assign stg[0][N + i] = net.blk_top[N - 1 - i];  // Descending half.
   end

   // ########################################
   // Half-cleaner levels
   // ########################################

   for (genvar l = 0; l < LVL; l++) begin : g_lvl
      localparam int S = N2 >> (l + 1);
      for (genvar i = 0; i < N2; i++) begin : g_rec
         if ((i & S) == 0) begin : g_cmp
            logic swap;

            assign swap = rec_key(stg[l][i]) > rec_key(stg[l][i + S]);
            assign stg[l + 1][i]     = swap ? stg[l][i + S] : stg[l][i];
            assign stg[l + 1][i + S] = swap ? stg[l][i] : stg[l][i + S];
         end
      end
   end

   for (genvar i = 0; i < N; i++) begin : g_out
      assign net.blk_lo[i] = stg[LVL][i];
      assign net.blk_hi[i] = stg[LVL][N + i];
   end

endmodule

// File: source/block_fifo.sv
`timescale 1ns/1ps

module block_fifo #(
   parameter int DEPTH = 8
) (
   input  logic            i_clk,
   input  logic            i_rst_n,
   input  logic            i_wr,
   input  merge_pkg::blk_t i_wr_blk,
   input  logic            i_rd,
   output merge_pkg::blk_t o_rd_blk,
   output logic            o_empty,
   output logic            o_full
);
   import merge_pkg::*;

   localparam int AW = $clog2(DEPTH);
   localparam int CW = AW + 1;

   blk_t            mem [DEPTH];
   logic [AW-1:0]   wr_ptr;
   logic [AW-1:0]   rd_ptr;
   logic [CW-1:0]   count;
   logic            do_wr;
   logic            do_rd;

   assign o_empty  = (count == '0);
   assign o_full   = (count == CW'(DEPTH));
   assign do_wr    = i_wr && !o_full;   // Write while full is dropped.
   assign do_rd    = i_rd && !o_empty;
   assign o_rd_blk = mem[rd_ptr];       // Head falls through.

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= i_wr_blk;
      end
   end

endmodule

// File: source/merge_net_if.sv
`timescale 1ns/1ps

interface merge_net_if;
   import merge_pkg::*;

   blk_t blk_new;  // Head block picked from A or B.
   blk_t blk_top;  // Held upper half of the last merge.
   blk_t blk_lo;
   blk_t blk_hi;

   modport ctrl (
      output blk_new,
      output blk_top,
      input  blk_lo,
      input  blk_hi
   );

   modport net (
      input  blk_new,
      input  blk_top,
      output blk_lo,
      output blk_hi
   );

endinterface

// File: source/merge_pkg.sv
`include "merge_consts.svh"

package merge_pkg;

   // ########################################
   // Record and block types
   // ########################################

   typedef logic [`MRG_REC_W-1:0] rec_t;
   typedef logic [`MRG_KEY_W-1:0] key_t;

   // Record 0 holds the smallest key.
   typedef rec_t [`MRG_BLK-1:0] blk_t;

   // ########################################
   // Merge control
   // ########################################

   typedef enum logic [1:0] {
      FILL,       // Waiting for the first block of a run pair.
      MERGE,
      FLUSH_TOP,  // Both runs ended, top block goes out.
      FLUSH_END   // Terminator block goes out.
   } ctrl_state_e;

   function automatic key_t rec_key(input rec_t r);
      return r[`MRG_KEY_W-1:0];
   endfunction

endpackage

// File: source/merge_consts.svh
`ifndef MERGE_CONSTS_SVH
`define MERGE_CONSTS_SVH

// Record layout. The sort key sits in the low bits.
`define MRG_REC_W 32
`define MRG_KEY_W 16

// Records per block, a power of two.
`define MRG_BLK 4

// Output FIFO depth in blocks.
`define MRG_OUT_DEPTH 8

`endif
